//--- all.f
boxerPkg.sv
holdTimer.sv
pixelScanner.sv
poseSequencer.sv
roundClock.sv
scoreBoard.sv
segmentDisplay.sv
boxerGame.sv
boxerGameTb.sv

//--- boxerGame.sv
module boxerGame #(
	parameter int FrameWidth = 320,
	parameter int FrameHeight = 240,
	parameter int CreditDepth = 4,
	parameter int PoseHoldTicks = 10000000,
	parameter int ResultHoldTicks = 50000000,
	parameter int TicksPerSecond = 50000000,
	parameter int RoundSeconds = 60
) (
	input logic clk,
	input logic reset,
	input logic start,
	input boxerPkg::strikeT strike,
	input logic credit,
	output boxerPkg::pixelT pixel,
	output logic pixelValid,
	output boxerPkg::segmentsT segments
);

	logic drawStart;
	boxerPkg::spriteT drawSprite;
	logic drawDone;
	logic poseHold;
	logic resultHold;
	logic poseDone;
	logic resultDone;
	logic roundOver;
	logic hit;
	logic miss;
	boxerPkg::scoreT seconds;
	boxerPkg::scoreT playerScore;
	boxerPkg::scoreT opponentScore;

	poseSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.strike(strike),
		.roundOver(roundOver),
		.drawDone(drawDone),
		.poseDone(poseDone),
		.resultDone(resultDone),
		.drawStart(drawStart),
		.drawSprite(drawSprite),
		.poseHold(poseHold),
		.resultHold(resultHold),
		.hit(hit),
		.miss(miss)
	);

	pixelScanner #(
		.FrameWidth(FrameWidth),
		.FrameHeight(FrameHeight),
		.CreditDepth(CreditDepth)
	) scanner (
		.clk(clk),
		.reset(reset),
		.drawStart(drawStart),
		.drawSprite(drawSprite),
		.credit(credit),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.drawDone(drawDone)
	);

	holdTimer #(.HoldTicks(PoseHoldTicks)) poseTimer (
		.clk(clk),
		.reset(reset),
		.enable(poseHold),
		.done(poseDone)
	);

	holdTimer #(.HoldTicks(ResultHoldTicks)) resultTimer (
		.clk(clk),
		.reset(reset),
		.enable(resultHold),
		.done(resultDone)
	);

	roundClock #(
		.TicksPerSecond(TicksPerSecond),
		.RoundSeconds(RoundSeconds)
	) clock (
		.clk(clk),
		.reset(reset),
		.start(start),
		.seconds(seconds),
		.roundOver(roundOver)
	);

	scoreBoard scores (
		.clk(clk),
		.reset(reset),
		.start(start),
		.hit(hit),
		.miss(miss),
		.playerScore(playerScore),
		.opponentScore(opponentScore)
	);

	segmentDisplay display (
		.digits({seconds, playerScore, opponentScore}),
		.segments(segments)
	);

endmodule

//--- boxerGameTb.sv
module boxerGameTb;

	localparam int FrameWidth = 8;
	localparam int FrameHeight = 4;
	localparam int CreditDepth = 4;
	localparam int PoseHoldTicks = 40;
	localparam int ResultHoldTicks = 60;
	localparam int TicksPerSecond = 50;
	localparam int RoundSeconds = 12;
	localparam int FramePixels = FrameWidth * FrameHeight;
	localparam int WaitLimit = 3000;

	// key levels as {center, side}
	localparam logic [1:0] KeyNone = 2'b00;
	localparam logic [1:0] KeyCenter = 2'b10;
	localparam logic [1:0] KeySide = 2'b01;

	typedef struct packed {
		logic [1:0] key;
		boxerPkg::spriteT pose;
		logic hasResult;
		boxerPkg::spriteT result;
		logic playerAdd;
		logic opponentAdd;
	} rowT;

	logic clk = 1'b0;
	logic reset = 1'b0;
	logic start = 1'b0;
	boxerPkg::strikeT strike = '0;
	logic credit = 1'b0;
	boxerPkg::pixelT pixel;
	logic pixelValid;
	boxerPkg::segmentsT segments;

	rowT rows [0:12];
	int cycle = 0;
	int issued = 0;
	int returned = 0;
	int pixCount = 0;
	int expX = 0;
	int expY = 0;
	int frameTotal = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int errAtTestStart = 0;
	logic holdCredits = 1'b0;
	logic [31:0] lfsr = 32'h1366;
	logic [1:0] delayBits;
	boxerPkg::spriteT frameSprite;
	boxerPkg::spriteT frameQ [$];
	int dueQ [$];

	boxerGame #(
		.FrameWidth(FrameWidth),
		.FrameHeight(FrameHeight),
		.CreditDepth(CreditDepth),
		.PoseHoldTicks(PoseHoldTicks),
		.ResultHoldTicks(ResultHoldTicks),
		.TicksPerSecond(TicksPerSecond),
		.RoundSeconds(RoundSeconds)
	) boxerGame_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.strike(strike),
		.credit(credit),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.segments(segments)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// standard active-low hex patterns with g in the top bit
	function automatic logic [6:0] glyph(int d);
		case (d)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0011000;
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic int decodeGlyph(logic [6:0] g);
		for (int d = 0; d < 10; d++)
			if (glyph(d) == g)
				return d;
		return -1;
	endfunction

	function automatic int readSeconds();
		return decodeGlyph(segments[1]) * 10 + decodeGlyph(segments[0]);
	endfunction

	task automatic check(string what, logic [63:0] actual, logic [63:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic checkScores(int p, int o);
		check("player ones", 64'(segments[2]), 64'(glyph(p % 10)));
		check("player tens", 64'(segments[3]), 64'(glyph(p / 10)));
		check("opponent ones", 64'(segments[4]), 64'(glyph(o % 10)));
		check("opponent tens", 64'(segments[5]), 64'(glyph(o / 10)));
	endtask

	task automatic endTest(string name);
		tests++;
		$display("test %s: %s", name, (errors == errAtTestStart) ? "ok" : "FAILED");
		errAtTestStart = errors;
	endtask

	task automatic waitFrame(output boxerPkg::spriteT sprite);
		int n;
		n = 0;
		while (frameQ.size() == 0 && n < WaitLimit)
		begin
			@(negedge clk);
			n++;
		end
		if (frameQ.size() == 0)
		begin
			$display("Timeout: no complete frame arrived within %0d cycles", WaitLimit);
			$display("Checks failed");
			$finish;
		end
		else
			sprite = frameQ.pop_front();
	endtask

	task automatic pulseStart();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic setRow(int idx, logic [1:0] key, boxerPkg::spriteT pose, logic hasResult,
		boxerPkg::spriteT result, logic playerAdd, logic opponentAdd);
		rows[idx] = '{key, pose, hasResult, result, playerAdd, opponentAdd};
	endtask

	// --------------------
	// pixel monitor counting credits where the DUT sees them
	always @(posedge clk)
	begin
		cycle++;
		if (credit)
			returned++;
		if (pixelValid)
		begin
			issued++;
			check("outstanding within credit depth", 64'(issued - returned <= CreditDepth), 64'(1));
			check("pixel x", 64'(pixel.x), 64'(expX));
			check("pixel y", 64'(pixel.y), 64'(expY));
			if (pixCount == 0)
				frameSprite = pixel.sprite;
			else
				check("sprite within frame", 64'(pixel.sprite), 64'(frameSprite));
			lfsr = lfsrNext(lfsr);
			delayBits[0] = lfsr[0];
			lfsr = lfsrNext(lfsr);
			delayBits[1] = lfsr[0];
			dueQ.push_back(cycle + 1 + int'(delayBits));
			expX++;
			if (expX == FrameWidth)
			begin
				expX = 0;
				expY++;
			end
			pixCount++;
			if (pixCount == FramePixels)
			begin
				frameQ.push_back(frameSprite);
				frameTotal++;
				pixCount = 0;
				expY = 0;
			end
		end
	end

	// credit responder
	always @(negedge clk)
	begin
		credit = 1'b0;
		if (!holdCredits && dueQ.size() > 0 && dueQ[0] <= cycle)
		begin
			credit = 1'b1;
			void'(dueQ.pop_front());
		end
	end

	// --------------------
	initial
	begin
		int i;
		int p;
		int o;
		int sec;
		int prevSec;
		int issuedBefore;
		int framesBefore;
		logic ended;
		boxerPkg::spriteT s;

		setRow(0, KeyNone, boxerPkg::center, 0, boxerPkg::endScreen, 0, 0);
		setRow(1, KeyCenter, boxerPkg::centerShuffle, 1, boxerPkg::hit, 1, 0);
		// key still held so no edge
		setRow(2, KeyCenter, boxerPkg::center, 0, boxerPkg::endScreen, 0, 0);
		setRow(3, KeySide, boxerPkg::centerShuffle, 1, boxerPkg::missed, 0, 1);
		setRow(4, KeyNone, boxerPkg::right, 0, boxerPkg::endScreen, 0, 0);
		setRow(5, KeySide, boxerPkg::rightShuffle, 1, boxerPkg::hit, 1, 0);
		setRow(6, KeyCenter, boxerPkg::right, 1, boxerPkg::missed, 0, 1);
		setRow(7, KeyNone, boxerPkg::center, 0, boxerPkg::endScreen, 0, 0);
		setRow(8, KeyCenter, boxerPkg::centerShuffle, 1, boxerPkg::hit, 1, 0);
		setRow(9, KeySide, boxerPkg::center, 1, boxerPkg::missed, 0, 1);
		setRow(10, KeySide, boxerPkg::left, 0, boxerPkg::endScreen, 0, 0);
		setRow(11, KeyNone, boxerPkg::leftShuffle, 0, boxerPkg::endScreen, 0, 0);
		setRow(12, KeyCenter, boxerPkg::left, 1, boxerPkg::missed, 0, 1);

		repeat (5) @(negedge clk);
		reset = 1'b1;

		// longer than one second so an early clock would show
		for (i = 0; i < 2 * TicksPerSecond; i++)
		begin
			@(negedge clk);
			check("idle pixelValid", 64'(pixelValid), 64'(0));
			checkScores(0, 0);
			check("idle seconds", 64'(readSeconds()), 64'(0));
		end
		endTest("reset idle");

		// with credits withheld only four pixels go out
		holdCredits = 1'b1;
		issuedBefore = issued;
		pulseStart();
		repeat (20) @(negedge clk);
		check("pixels issued while stalled", 64'(issued - issuedBefore), 64'(CreditDepth));
		check("pixelValid while stalled", 64'(pixelValid), 64'(0));
		holdCredits = 1'b0;
		endTest("credit stall");

		p = 0;
		o = 0;
		prevSec = 0;
		ended = 1'b0;
		i = 0;
		while (!ended && i < 40)
		begin
			waitFrame(s);
			if (s == boxerPkg::endScreen)
				ended = 1'b1;
			else
			begin
				check("pose sprite", 64'(s), 64'(rows[i % 13].pose));
				checkScores(p, o);
				sec = readSeconds();
				check("seconds rising", 64'(sec >= prevSec && sec <= RoundSeconds), 64'(1));
				prevSec = sec;
				if (i < 13)
				begin
					strike = rows[i].key;
					if (rows[i].hasResult)
					begin
						waitFrame(s);
						if (s == boxerPkg::endScreen)
							ended = 1'b1;
						else
						begin
							check("result sprite", 64'(s), 64'(rows[i].result));
							p = p + int'(rows[i].playerAdd);
							o = o + int'(rows[i].opponentAdd);
						end
					end
				end
				else
					strike = '0;
				i++;
			end
		end
		strike = '0;
		check("round one reached the end screen", 64'(ended), 64'(1));
		endTest("judging and routine");

		@(negedge clk);
		checkScores(p, o);
		check("final seconds", 64'(readSeconds()), 64'(RoundSeconds));
		framesBefore = frameTotal;
		issuedBefore = issued;
		for (i = 0; i < 100; i++)
		begin
			@(negedge clk);
			strike = i[3] ? KeyCenter : KeySide;
		end
		strike = '0;
		@(negedge clk);
		check("frames after end", 64'(frameTotal), 64'(framesBefore));
		check("pixels after end", 64'(issued), 64'(issuedBefore));
		check("seconds frozen after end", 64'(readSeconds()), 64'(RoundSeconds));
		checkScores(p, o);
		endTest("end screen");

		pulseStart();
		@(negedge clk);
		checkScores(0, 0);
		check("seconds after start", 64'(readSeconds()), 64'(0));
		waitFrame(s);
		check("first pose after start", 64'(s), 64'(rows[0].pose));
		endTest("restart");

		ended = 1'b0;
		i = 1;
		while (!ended && i < 40)
		begin
			waitFrame(s);
			if (s == boxerPkg::endScreen)
				ended = 1'b1;
			else
			begin
				check("routine order", 64'(s), 64'(rows[i % 13].pose));
				i++;
			end
		end
		check("round two reached the end screen", 64'(ended), 64'(1));
		check("round two seconds", 64'(readSeconds()), 64'(RoundSeconds));
		checkScores(0, 0);
		endTest("routine order");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- boxerPkg.sv
package boxerPkg;

	typedef logic [3:0] bcdDigitT;
	typedef logic [8:0] coordXT;
	typedef logic [7:0] coordYT;

	typedef enum logic [3:0] {
		endScreen = 4'd0,
		center = 4'd1,
		right = 4'd2,
		left = 4'd3,
		hit = 4'd4,
		centerShuffle = 4'd5,
		missed = 4'd6,
		rightShuffle = 4'd7,
		leftShuffle = 4'd8
	} spriteT;

	typedef enum logic {
		zoneCenter,
		zoneSide
	} zoneT;

	typedef struct packed {
		logic center;
		logic side;
	} strikeT;

	typedef struct packed {
		coordXT x;
		coordYT y;
		spriteT sprite;
	} pixelT;

	typedef struct packed {
		bcdDigitT tens;
		bcdDigitT ones;
	} scoreT;

	typedef struct packed {
		scoreT seconds;
		scoreT player;
		scoreT opponent;
	} displayDigitsT;

	// one active-low pattern per digit
	typedef logic [5:0][6:0] segmentsT;

	typedef struct packed {
		spriteT sprite;
		zoneT zone;
	} poseStepT;

	// --------------------
	// pose routine
	localparam int RoutineLength = 13;

	localparam poseStepT Routine [0:RoutineLength-1] = '{
		'{center, zoneCenter},
		'{centerShuffle, zoneCenter},
		'{center, zoneCenter},
		'{centerShuffle, zoneCenter},
		'{right, zoneSide},
		'{rightShuffle, zoneSide},
		'{right, zoneSide},
		'{center, zoneCenter},
		'{centerShuffle, zoneCenter},
		'{center, zoneCenter},
		'{left, zoneSide},
		'{leftShuffle, zoneSide},
		'{left, zoneSide}
	};

	// two-digit bcd step, wraps 99 to 00
	function automatic scoreT bcdIncrement(scoreT value);
		scoreT result;
		result = value;
		if (value.ones == 4'd9)
		begin
			result.ones = 4'd0;
			result.tens = (value.tens == 4'd9) ? 4'd0 : value.tens + 4'd1;
		end
		else
			result.ones = value.ones + 4'd1;
		return result;
	endfunction

endpackage

//--- holdTimer.sv
module holdTimer #(
	parameter int HoldTicks = 10000000
) (
	input logic clk,
	input logic reset,
	input logic enable,
	output logic done
);

	localparam int CountW = $clog2(HoldTicks + 1);

	logic [CountW-1:0] count;

	// saturates so done fires once per hold
	always_ff @(posedge clk)
	begin
		if (!reset || !enable)
		begin
			count <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= count == CountW'(HoldTicks - 1);
			if (count != CountW'(HoldTicks))
				count <= count + 1'b1;
		end
	end

endmodule

//--- pixelScanner.sv
module pixelScanner #(
	parameter int FrameWidth = 320,
	parameter int FrameHeight = 240,
	parameter int CreditDepth = 4
) (
	input logic clk,
	input logic reset,
	input logic drawStart,
	input boxerPkg::spriteT drawSprite,
	input logic credit,
	output boxerPkg::pixelT pixel,
	output logic pixelValid,
	output logic drawDone
);

	localparam int CreditW = $clog2(CreditDepth + 1);

	boxerPkg::coordXT x;
	boxerPkg::coordYT y;
	boxerPkg::spriteT sprite;
	logic active;
	logic [CreditW-1:0] creditCount;
	logic [CreditW-1:0] creditNext;
	logic lastX;
	logic lastY;

	assign lastX = x == boxerPkg::coordXT'(FrameWidth - 1);
	assign lastY = y == boxerPkg::coordYT'(FrameHeight - 1);

	// stalls in place while no credit is left
	assign pixelValid = active && creditCount != '0;
	assign drawDone = pixelValid && lastX && lastY;
	assign pixel = {x, y, sprite};

	// credit bookkeeping, capped at depth
	always_comb
	begin
		creditNext = creditCount;
		if (credit && !pixelValid && creditCount != CreditW'(CreditDepth))
			creditNext = creditCount + 1'b1;
		else if (!credit && pixelValid)
			creditNext = creditCount - 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			active <= 1'b0;
			x <= '0;
			y <= '0;
			creditCount <= CreditW'(CreditDepth);
		end
		else
		begin
			creditCount <= creditNext;
			if (drawStart)
			begin
				active <= 1'b1;
				x <= '0;
				y <= '0;
			end
			else if (pixelValid)
			begin
				if (lastX)
				begin
					x <= '0;
					if (lastY)
					begin
						y <= '0;
						active <= 1'b0;
					end
					else
						y <= y + 1'b1;
				end
				else
					x <= x + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (drawStart)
			sprite <= drawSprite;
	end

endmodule

//--- poseSequencer.sv
module poseSequencer (
	input logic clk,
	input logic reset,
	input logic start,
	input boxerPkg::strikeT strike,
	input logic roundOver,
	input logic drawDone,
	input logic poseDone,
	input logic resultDone,
	output logic drawStart,
	output boxerPkg::spriteT drawSprite,
	output logic poseHold,
	output logic resultHold,
	output logic hit,
	output logic miss
);

	localparam int StepW = $clog2(boxerPkg::RoutineLength);

	typedef enum logic [2:0] {
		idle,
		drawPose,
		holdPose,
		drawResult,
		holdResult,
		drawEnd,
		finished
	} stateT;

	stateT state;
	stateT nextState;
	logic [StepW-1:0] step;
	logic [StepW-1:0] nextStep;
	logic [StepW-1:0] advancedStep;
	boxerPkg::strikeT prevStrike;
	logic prevStart;
	logic centerRise;
	logic sideRise;
	boxerPkg::zoneT struckZone;
	logic hitNow;
	logic missNow;
	logic enterDraw;
	boxerPkg::spriteT entrySprite;

	// key edges, center wins a tie
	assign centerRise = strike.center && !prevStrike.center;
	assign sideRise = strike.side && !prevStrike.side;
	assign struckZone = centerRise ? boxerPkg::zoneCenter : boxerPkg::zoneSide;

	assign advancedStep = (step == StepW'(boxerPkg::RoutineLength - 1)) ? '0 : step + 1'b1;

	assign poseHold = state == holdPose;
	assign resultHold = state == holdResult;

	// --------------------
	// next state
	always_comb
	begin
		nextState = state;
		nextStep = step;
		hitNow = 1'b0;
		missNow = 1'b0;
		if (start)
		begin
			nextState = idle;
			nextStep = '0;
		end
		else
		begin
			case (state)
				idle:
					// game begins once start is released
					if (prevStart)
						nextState = drawPose;
				drawPose:
					if (drawDone)
						nextState = roundOver ? drawEnd : holdPose;
				holdPose:
					if (roundOver)
						nextState = drawEnd;
					else if (centerRise || sideRise)
					begin
						hitNow = struckZone == boxerPkg::Routine[step].zone;
						missNow = !hitNow;
						nextState = drawResult;
					end
					else if (poseDone)
					begin
						nextState = drawPose;
						nextStep = advancedStep;
					end
				drawResult:
					if (drawDone)
						nextState = roundOver ? drawEnd : holdResult;
				holdResult:
					if (roundOver)
						nextState = drawEnd;
					else if (resultDone)
					begin
						nextState = drawPose;
						nextStep = advancedStep;
					end
				drawEnd:
					if (drawDone)
						nextState = finished;
				default:
					nextState = finished;
			endcase
		end
	end

	// sprite for the frame about to start
	always_comb
	begin
		enterDraw = (nextState != state) &&
			(nextState == drawPose || nextState == drawResult || nextState == drawEnd);
		case (nextState)
			drawResult:
				entrySprite = hitNow ? boxerPkg::hit : boxerPkg::missed;
			drawEnd:
				entrySprite = boxerPkg::endScreen;
			default:
				entrySprite = boxerPkg::Routine[nextStep].sprite;
		endcase
	end

	// --------------------
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state <= idle;
			step <= '0;
			prevStrike <= '0;
			prevStart <= 1'b0;
			drawStart <= 1'b0;
			hit <= 1'b0;
			miss <= 1'b0;
		end
		else
		begin
			state <= nextState;
			step <= nextStep;
			prevStrike <= strike;
			prevStart <= start;
			drawStart <= enterDraw;
			hit <= hitNow;
			miss <= missNow;
		end
	end

	always_ff @(posedge clk)
	begin
		if (enterDraw)
			drawSprite <= entrySprite;
	end

endmodule

//--- roundClock.sv
module roundClock #(
	parameter int TicksPerSecond = 50000000,
	parameter int RoundSeconds = 60
) (
	input logic clk,
	input logic reset,
	input logic start,
	output boxerPkg::scoreT seconds,
	output logic roundOver
);

	localparam int PrescaleW = $clog2(TicksPerSecond + 1);
	localparam boxerPkg::bcdDigitT RoundTens = boxerPkg::bcdDigitT'(RoundSeconds / 10);
	localparam boxerPkg::bcdDigitT RoundOnes = boxerPkg::bcdDigitT'(RoundSeconds % 10);

	logic [PrescaleW-1:0] prescale;
	logic running;
	logic secondTick;

	// count freezes on the round length
	assign roundOver = seconds.tens == RoundTens && seconds.ones == RoundOnes;
	assign secondTick = prescale == PrescaleW'(TicksPerSecond - 1);

	// --------------------
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			prescale <= '0;
			seconds <= '0;
			running <= 1'b0;
		end
		else if (start)
		begin
			prescale <= '0;
			seconds <= '0;
			running <= 1'b1;
		end
		else if (running && !roundOver)
		begin
			if (secondTick)
			begin
				prescale <= '0;
				seconds <= boxerPkg::bcdIncrement(seconds);
			end
			else
				prescale <= prescale + 1'b1;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module boxerGameTb -Mdir obj_dir -o simv
./obj_dir/simv > sim.log
cat sim.log
if grep -q "All checks passed" sim.log; then
	exit 0
fi
exit 1

//--- scoreBoard.sv
module scoreBoard (
	input logic clk,
	input logic reset,
	input logic start,
	input logic hit,
	input logic miss,
	output boxerPkg::scoreT playerScore,
	output boxerPkg::scoreT opponentScore
);

	// player side
	always_ff @(posedge clk)
	begin
		if (!reset)
			playerScore <= '0;
		else if (start)
			playerScore <= '0;
		else if (hit)
			playerScore <= boxerPkg::bcdIncrement(playerScore);
	end

	// opponent side
	always_ff @(posedge clk)
	begin
		if (!reset)
			opponentScore <= '0;
		else if (start)
			opponentScore <= '0;
		else if (miss)
			opponentScore <= boxerPkg::bcdIncrement(opponentScore);
	end

endmodule

//--- segmentDisplay.sv
module segmentDisplay (
	input boxerPkg::displayDigitsT digits,
	output boxerPkg::segmentsT segments
);

	// hex glyphs, segment g in the top bit
	localparam logic [6:0] Glyphs [0:15] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

	boxerPkg::bcdDigitT digitList [0:5];

	// lowest display is seconds ones
	assign digitList[0] = digits.seconds.ones;
	assign digitList[1] = digits.seconds.tens;
	assign digitList[2] = digits.player.ones;
	assign digitList[3] = digits.player.tens;
	assign digitList[4] = digits.opponent.ones;
	assign digitList[5] = digits.opponent.tens;

	always_comb
	begin
		for (int i = 0; i < 6; i++)
			segments[i] = Glyphs[digitList[i]];
	end

endmodule
